// ==== source/fetch_pkg.sv ====
package fetch_pkg;

    localparam int ADDR_W  = 32;  // byte address
    localparam int INSTR_W = 32;

    // instruction fields
    localparam int OPC_LSB = 28;  // opcode in [31:28]
    localparam int IMM_W   = 16;  // signed word offset in [15:0]

    // major opcodes of the toy isa
    typedef enum logic [3:0] {
        OP_ALU   = 4'h0,
        OP_LOAD  = 4'h1,
        OP_STORE = 4'h2,
        OP_BCC   = 4'h3,  // conditional branch
        OP_JMP   = 4'h4   // unconditional jump
    } opcode_e;

endpackage

// ==== source/mem_pkg.sv ====
package mem_pkg;

    localparam int APB_DATA_W = 32;  // one instruction per beat
    localparam int BEAT_BYTES = 4;   // address step between beats

    // refill engine states
    typedef enum logic [1:0] {
        RF_IDLE,    // waiting for a miss
        RF_SETUP,   // apb setup phase
        RF_ACCESS,  // apb access phase, waits on pready
        RF_FILL     // line complete, written into the cache
    } refill_state_e;

endpackage

// ==== source/pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         redirect_valid,
    input  logic [fetch_pkg::ADDR_W-1:0] redirect_pc,
    input  logic                         hit,
    input  logic                         full,
    input  logic                         backend_stall,
    input  logic [fetch_pkg::INSTR_W-1:0] instr,
    output logic [fetch_pkg::ADDR_W-1:0] pc,
    output logic                         advance,
    output logic                         pred_taken,
    output logic [fetch_pkg::ADDR_W-1:0] pred_target
);

    fetch_pkg::opcode_e                  opc;
    logic signed [fetch_pkg::IMM_W-1:0]  imm;
    logic [fetch_pkg::ADDR_W-1:0]        offset;    // sign extended imm * 4
    logic [fetch_pkg::ADDR_W-1:0]        seq_pc;
    logic [fetch_pkg::ADDR_W-1:0]        br_pc;
    logic [fetch_pkg::ADDR_W-1:0]        next_pc;

    // predecode of the word the cache is returning
    assign opc = fetch_pkg::opcode_e'(instr[fetch_pkg::OPC_LSB +: $bits(fetch_pkg::opcode_e)]);
    assign imm = instr[fetch_pkg::IMM_W-1:0];

    assign offset = {{(fetch_pkg::ADDR_W-fetch_pkg::IMM_W-2){imm[fetch_pkg::IMM_W-1]}},
                     imm, 2'b00};
    assign seq_pc = pc + 32'd4;
    assign br_pc  = pc + offset;

    // static rule takes jmp always and bcc only backward
    always_comb begin
        case (opc)
            fetch_pkg::OP_JMP: pred_taken = 1'b1;
            fetch_pkg::OP_BCC: pred_taken = imm[fetch_pkg::IMM_W-1];  // sign bit
            default:           pred_taken = 1'b0;
        endcase
    end

    assign pred_target = pred_taken ? br_pc : seq_pc;

    // enqueue strobe and pc step enable
    assign advance = hit && !full && !backend_stall && !redirect_valid;

    always_comb begin
        if (redirect_valid) begin
            next_pc = {redirect_pc[fetch_pkg::ADDR_W-1:2], 2'b00};  // word aligned
        end else if (advance) begin
            next_pc = pred_target;
        end else begin
            next_pc = pc;  // miss, full or stall
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    a_pc_aligned : assert property (@(posedge clk) disable iff (!arst_n)
        pc[1:0] == 2'b00)
        else $error("pc lost word alignment");

endmodule

// ==== source/icache.sv ====
`timescale 1ns/1ps

module icache #(
    parameter int LINE_WORDS = 4,
    parameter int NUM_LINES  = 16
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [fetch_pkg::ADDR_W-1:0]  pc,
    input  logic                          fill_valid,
    input  logic [$clog2(NUM_LINES)-1:0]  fill_index,
    input  logic [fetch_pkg::ADDR_W-$clog2(NUM_LINES)-$clog2(LINE_WORDS)-3:0] fill_tag,
    input  logic [LINE_WORDS-1:0][fetch_pkg::INSTR_W-1:0] fill_line,
    output logic                          hit,
    output logic [fetch_pkg::INSTR_W-1:0] instr,
    output logic [fetch_pkg::ADDR_W-1:0]  miss_addr
);

    localparam int OFF_W = $clog2(LINE_WORDS);
    localparam int IDX_W = $clog2(NUM_LINES);
    localparam int TAG_W = fetch_pkg::ADDR_W - IDX_W - OFF_W - 2;

    logic [NUM_LINES-1:0]                         valid;
    logic [TAG_W-1:0]                             tag_mem  [NUM_LINES];
    logic [LINE_WORDS-1:0][fetch_pkg::INSTR_W-1:0] data_mem [NUM_LINES];

    logic [OFF_W-1:0] word_off;
    logic [IDX_W-1:0] index;
    logic [TAG_W-1:0] tag;

    // pc = | tag | index | word | 2'b00 |
    assign word_off = pc[2 +: OFF_W];
    assign index    = pc[2+OFF_W +: IDX_W];
    assign tag      = pc[fetch_pkg::ADDR_W-1 -: TAG_W];

    // combinational lookup on the pc register
    assign hit   = valid[index] && (tag_mem[index] == tag);
    assign instr = data_mem[index][word_off];

    // refill always starts at word 0 of the line
    assign miss_addr = {pc[fetch_pkg::ADDR_W-1:2+OFF_W], {(OFF_W+2){1'b0}}};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;  // cold cache
        end else if (fill_valid) begin
            valid[fill_index] <= 1'b1;
        end
    end

    // whole line plus its tag in one cycle
    always_ff @(posedge clk) begin
        if (fill_valid) begin
            tag_mem[fill_index]  <= fill_tag;
            data_mem[fill_index] <= fill_line;
        end
    end

endmodule

// ==== source/refill_fsm.sv ====
`timescale 1ns/1ps

module refill_fsm #(
    parameter int LINE_WORDS = 4,
    parameter int NUM_LINES  = 16
) (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             hit,
    input  logic [fetch_pkg::ADDR_W-1:0]     miss_addr,
    input  logic [mem_pkg::APB_DATA_W-1:0]   prdata,
    input  logic                             pready,
    input  logic                             pslverr,
    output logic [fetch_pkg::ADDR_W-1:0]     paddr,
    output logic                             psel,
    output logic                             penable,
    output logic                             fill_valid,
    output logic [$clog2(NUM_LINES)-1:0]     fill_index,
    output logic [fetch_pkg::ADDR_W-$clog2(NUM_LINES)-$clog2(LINE_WORDS)-3:0] fill_tag,
    output logic [LINE_WORDS-1:0][fetch_pkg::INSTR_W-1:0] fill_line
);

    localparam int OFF_W = $clog2(LINE_WORDS);
    localparam int IDX_W = $clog2(NUM_LINES);
    localparam logic [OFF_W-1:0] LAST_BEAT = OFF_W'(LINE_WORDS - 1);

    mem_pkg::refill_state_e                       state;
    logic [OFF_W-1:0]                             beat;       // word within the line
    logic [fetch_pkg::ADDR_W-1:0]                 line_addr;  // latched at miss
    logic [fetch_pkg::ADDR_W-1:0]                 beat_off;
    logic [LINE_WORDS-1:0][mem_pkg::APB_DATA_W-1:0] line_buf;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= mem_pkg::RF_IDLE;
            beat      <= '0;
            line_addr <= '0;
        end else begin
            case (state)
                mem_pkg::RF_IDLE: begin
                    if (!hit) begin
                        line_addr <= miss_addr;  // later redirects do not move it
                        beat      <= '0;
                        state     <= mem_pkg::RF_SETUP;
                    end
                end
                mem_pkg::RF_SETUP: state <= mem_pkg::RF_ACCESS;
                mem_pkg::RF_ACCESS: begin
                    if (pready) begin
                        if (pslverr) begin
                            state <= mem_pkg::RF_IDLE;  // drop the line, miss comes back
                        end else if (beat == LAST_BEAT) begin
                            state <= mem_pkg::RF_FILL;
                        end else begin
                            beat  <= beat + 1'b1;
                            state <= mem_pkg::RF_SETUP;  // next beat
                        end
                    end
                end
                default: state <= mem_pkg::RF_IDLE;  // RF_FILL lasts one cycle
            endcase
        end
    end

    // first word ends up in slot 0 after the last shift
    always_ff @(posedge clk) begin
        if (state == mem_pkg::RF_ACCESS && pready && !pslverr) begin
            line_buf <= {prdata, line_buf[LINE_WORDS-1:1]};
        end
    end

    assign beat_off = beat * mem_pkg::BEAT_BYTES;
    assign paddr    = line_addr + beat_off;  // only moves between beats

    assign psel    = (state == mem_pkg::RF_SETUP) || (state == mem_pkg::RF_ACCESS);
    assign penable = (state == mem_pkg::RF_ACCESS);

    assign fill_valid = (state == mem_pkg::RF_FILL);
    assign fill_index = line_addr[2+OFF_W +: IDX_W];
    assign fill_tag   = line_addr[fetch_pkg::ADDR_W-1:2+OFF_W+IDX_W];
    assign fill_line  = line_buf;

    a_setup_first : assert property (@(posedge clk) disable iff (!arst_n)
        $rose(penable) |-> $past(psel) && !$past(penable))
        else $error("apb access without setup cycle");

    a_paddr_stable : assert property (@(posedge clk) disable iff (!arst_n)
        psel && !(penable && pready) |=> $stable(paddr))
        else $error("paddr changed inside a transfer");

endmodule

// ==== source/instr_fifo.sv ====
`timescale 1ns/1ps

module instr_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          flush,
    input  logic                          push,
    input  logic [fetch_pkg::INSTR_W-1:0] push_instr,
    input  logic [fetch_pkg::ADDR_W-1:0]  push_pc,
    input  logic                          push_taken,
    input  logic [fetch_pkg::ADDR_W-1:0]  push_target,
    input  logic                          deq_ready,
    output logic                          full,
    output logic                          deq_valid,
    output logic [fetch_pkg::INSTR_W-1:0] deq_instr,
    output logic [fetch_pkg::ADDR_W-1:0]  deq_pc,
    output logic                          deq_pred_taken,
    output logic [fetch_pkg::ADDR_W-1:0]  deq_pred_target
);

    localparam int PTR_W   = $clog2(FIFO_DEPTH);
    localparam int ENTRY_W = fetch_pkg::INSTR_W + 2 * fetch_pkg::ADDR_W + 1;
    localparam logic [PTR_W-1:0] LAST = PTR_W'(FIFO_DEPTH - 1);

    logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;
    logic               do_push;
    logic               do_pop;

    assign full      = (count == (PTR_W+1)'(FIFO_DEPTH));
    assign deq_valid = (count != '0);

    assign do_push = push && !full;
    assign do_pop  = deq_valid && deq_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;  // drops everything fetched down the old path
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            count <= count + do_push - do_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= {push_instr, push_pc, push_taken, push_target};
        end
    end

    // head entry, held while dispatch is not ready
    assign {deq_instr, deq_pc, deq_pred_taken, deq_pred_target} = mem[rd_ptr];

    a_no_push_full : assert property (@(posedge clk) disable iff (!arst_n)
        push |-> !full)
        else $error("fetch pushed into a full fifo");

endmodule

// ==== source/ifu_top.sv ====
`timescale 1ns/1ps

module ifu_top #(
    parameter int LINE_WORDS = 4,
    parameter int NUM_LINES  = 16,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                           clk,
    input  logic                           arst_n,
    // backend
    input  logic                           redirect_valid,
    input  logic [fetch_pkg::ADDR_W-1:0]   redirect_pc,
    input  logic                           backend_stall,
    // dispatch
    input  logic                           deq_ready,
    output logic                           deq_valid,
    output logic [fetch_pkg::INSTR_W-1:0]  deq_instr,
    output logic [fetch_pkg::ADDR_W-1:0]   deq_pc,
    output logic                           deq_pred_taken,
    output logic [fetch_pkg::ADDR_W-1:0]   deq_pred_target,
    // apb read master
    output logic [fetch_pkg::ADDR_W-1:0]   paddr,
    output logic                           psel,
    output logic                           penable,
    input  logic [mem_pkg::APB_DATA_W-1:0] prdata,
    input  logic                           pready,
    input  logic                           pslverr
);

    localparam int IDX_W = $clog2(NUM_LINES);
    localparam int TAG_W = fetch_pkg::ADDR_W - IDX_W - $clog2(LINE_WORDS) - 2;

    logic [fetch_pkg::ADDR_W-1:0]  pc;
    logic [fetch_pkg::INSTR_W-1:0] instr;
    logic                          hit;
    logic                          full;
    logic                          advance;     // enqueue this pc
    logic                          pred_taken;
    logic [fetch_pkg::ADDR_W-1:0]  pred_target;
    logic [fetch_pkg::ADDR_W-1:0]  miss_addr;   // line base of pc
    logic                          fill_valid;
    logic [IDX_W-1:0]              fill_index;
    logic [TAG_W-1:0]              fill_tag;
    logic [LINE_WORDS-1:0][fetch_pkg::INSTR_W-1:0] fill_line;

    pc_gen u_pc_gen (
        .clk            (clk),
        .arst_n         (arst_n),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .hit            (hit),
        .full           (full),
        .backend_stall  (backend_stall),
        .instr          (instr),
        .pc             (pc),
        .advance        (advance),
        .pred_taken     (pred_taken),
        .pred_target    (pred_target)
    );

    icache #(
        .LINE_WORDS (LINE_WORDS),
        .NUM_LINES  (NUM_LINES)
    ) u_icache (
        .clk        (clk),
        .arst_n     (arst_n),
        .pc         (pc),
        .fill_valid (fill_valid),
        .fill_index (fill_index),
        .fill_tag   (fill_tag),
        .fill_line  (fill_line),
        .hit        (hit),
        .instr      (instr),
        .miss_addr  (miss_addr)
    );

    refill_fsm #(
        .LINE_WORDS (LINE_WORDS),
        .NUM_LINES  (NUM_LINES)
    ) u_refill_fsm (
        .clk        (clk),
        .arst_n     (arst_n),
        .hit        (hit),
        .miss_addr  (miss_addr),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .fill_valid (fill_valid),
        .fill_index (fill_index),
        .fill_tag   (fill_tag),
        .fill_line  (fill_line)
    );

    instr_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_instr_fifo (
        .clk             (clk),
        .arst_n          (arst_n),
        .flush           (redirect_valid),  // empty on redirect
        .push            (advance),
        .push_instr      (instr),
        .push_pc         (pc),
        .push_taken      (pred_taken),
        .push_target     (pred_target),
        .deq_ready       (deq_ready),
        .full            (full),
        .deq_valid       (deq_valid),
        .deq_instr       (deq_instr),
        .deq_pc          (deq_pc),
        .deq_pred_taken  (deq_pred_taken),
        .deq_pred_target (deq_pred_target)
    );

endmodule

// ==== verification/tb_ifu.sv ====
`timescale 1ns/1ps

module tb_ifu;

    localparam int LINE_WORDS = 4;
    localparam int LINE_BYTES = LINE_WORDS * mem_pkg::BEAT_BYTES;
    localparam int RUN_CYCLES = 3000;
    localparam int MIN_DEQ    = 200;
    localparam int MAX_CYCLES = 20000;  // hard stop for the whole run
    localparam int IDLE_LIMIT = 1000;   // cycles without any dequeue

    logic                           clk;
    logic                           arst_n;
    logic                           redirect_valid;
    logic [fetch_pkg::ADDR_W-1:0]   redirect_pc;
    logic                           backend_stall;
    logic                           deq_ready;
    logic                           deq_valid;
    logic [fetch_pkg::INSTR_W-1:0]  deq_instr;
    logic [fetch_pkg::ADDR_W-1:0]   deq_pc;
    logic                           deq_pred_taken;
    logic [fetch_pkg::ADDR_W-1:0]   deq_pred_target;
    logic [fetch_pkg::ADDR_W-1:0]   paddr;
    logic                           psel;
    logic                           penable;
    logic [mem_pkg::APB_DATA_W-1:0] prdata;
    logic                           pready;
    logic                           pslverr;

    logic [31:0] rng_state;
    logic [31:0] imem [logic [31:0]];  // word address to instruction, made on first touch

    logic [31:0] exp_pc;               // reference fetch model
    int          cycle;
    int          deq_count;
    int          idle_cycles;
    int          ready_low;            // forced deq_ready low stretch
    logic        beat_active;          // apb slave inside a beat
    int          wait_left;
    logic        in_refill;
    logic        retry_pending;
    logic        redirect_in_refill;
    logic [31:0] refill_base;
    logic [31:0] retry_base;
    int          beat_idx;
    logic        prev_psel;
    logic        prev_penable;
    logic [31:0] prev_paddr;
    logic        prev_redirect;
    logic        held;                 // head entry must stay put
    logic [31:0] held_instr;
    logic [31:0] held_pc;
    logic        held_taken;
    logic [31:0] held_target;

    ifu_top #(
        .LINE_WORDS (LINE_WORDS),
        .NUM_LINES  (16),
        .FIFO_DEPTH (8)
    ) dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    function automatic logic [31:0] rand_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int rand_below(int n);
        return int'(rand_next() >> 8) % n;  // upper bits, better spread
    endfunction

    function automatic logic [31:0] make_instr();
        fetch_pkg::opcode_e opc;
        logic [15:0]        imm;
        logic [31:0]        r;
        case (rand_below(5))
            0:       opc = fetch_pkg::OP_ALU;
            1:       opc = fetch_pkg::OP_LOAD;
            2:       opc = fetch_pkg::OP_STORE;
            3:       opc = fetch_pkg::OP_BCC;
            default: opc = fetch_pkg::OP_JMP;
        endcase
        imm = 16'(rand_below(17)) - 16'd8;  // -8 .. +8 words
        r   = rand_next();
        return {opc, r[11:0], imm};
    endfunction

    function automatic logic [31:0] mem_word(logic [31:0] addr);
        logic [31:0] waddr;
        waddr = {addr[31:2], 2'b00};
        if (!imem.exists(waddr)) begin
            imem[waddr] = make_instr();
        end
        return imem[waddr];
    endfunction

    // static prediction, straight from the isa rules
    function automatic logic rule_taken(logic [31:0] word);
        logic [3:0] opc;
        opc = word[31:28];
        return (opc == fetch_pkg::OP_JMP) || (opc == fetch_pkg::OP_BCC && word[15]);
    endfunction

    function automatic logic [31:0] rule_next_pc(logic [31:0] pc, logic [31:0] word);
        int off;
        off = $signed(word[15:0]);
        return rule_taken(word) ? pc + 32'(off * 4) : pc + 32'd4;
    endfunction

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    // protocol and refill address checks, on values settled since the last rising edge
    task automatic observe_apb();
        assert (!penable || psel)
            else abort_run($sformatf("FAIL %0t: penable high without psel", $time));
        if (penable && !prev_penable) begin
            assert (prev_psel)
                else abort_run($sformatf("FAIL %0t: access phase without setup", $time));
        end
        if (prev_psel && !(prev_penable && pready)) begin
            assert (paddr == prev_paddr)
                else abort_run($sformatf("FAIL %0t: paddr moved %h -> %h inside a transfer",
                                         $time, prev_paddr, paddr));
        end
        if (prev_penable && pready) begin   // beat ended at the last edge
            if (pslverr) begin
                in_refill     = 1'b0;
                retry_pending = !redirect_in_refill;  // pc moved, other line may come
                retry_base    = refill_base;
            end else if (beat_idx == LINE_WORDS - 1) begin
                in_refill = 1'b0;
            end else begin
                beat_idx++;
            end
        end
        if (psel && !penable) begin         // setup cycle
            if (!in_refill) begin
                assert (paddr % LINE_BYTES == 0)
                    else abort_run($sformatf("FAIL %0t: refill start %h not line aligned",
                                             $time, paddr));
                if (retry_pending) begin
                    assert (paddr == retry_base)
                        else abort_run($sformatf("FAIL %0t: retry at %h, failed line %h",
                                                 $time, paddr, retry_base));
                end
                retry_pending      = 1'b0;
                in_refill          = 1'b1;
                redirect_in_refill = 1'b0;
                refill_base        = paddr;
                beat_idx           = 0;
            end else begin
                assert (paddr == refill_base + 32'(beat_idx * 4))
                    else abort_run($sformatf("FAIL %0t: beat %0d at %h, line base %h",
                                             $time, beat_idx, paddr, refill_base));
            end
        end
        prev_psel    = psel;
        prev_penable = penable;
        prev_paddr   = paddr;
    endtask

    // memory side, 0..3 wait states, rare slave error
    task automatic serve_apb();
        if (psel && penable) begin
            if (!beat_active) begin
                beat_active = 1'b1;
                wait_left   = rand_below(4);
            end
            if (wait_left == 0) begin
                pready      = 1'b1;
                prdata      = mem_word(paddr);
                pslverr     = (rand_below(40) == 0);
                beat_active = 1'b0;
            end else begin
                wait_left--;
                pready = 1'b0;
            end
        end else begin
            pready  = 1'b0;
            pslverr = 1'b0;
            prdata  = '0;
        end
    endtask

    task automatic drive_backend();
        backend_stall  = (rand_below(10) == 0);
        redirect_valid = (rand_below(60) == 0);
        redirect_pc    = 32'(rand_below(256) * 4);  // 1 KB window
        if (redirect_valid && in_refill) begin
            redirect_in_refill = 1'b1;
        end
        if (ready_low > 0) begin
            deq_ready = 1'b0;
            ready_low--;
        end else if (rand_below(150) == 0) begin
            deq_ready = 1'b0;
            ready_low = 20 + rand_below(30);  // long back-pressure stretch
        end else begin
            deq_ready = (rand_below(10) < 7);
        end
    endtask

    task automatic observe_dispatch();
        logic [31:0] word;
        if (prev_redirect) begin
            assert (!deq_valid)
                else abort_run($sformatf("FAIL %0t: entry left after redirect", $time));
        end
        if (held) begin
            assert (deq_valid && deq_instr == held_instr && deq_pc == held_pc &&
                    deq_pred_taken == held_taken && deq_pred_target == held_target)
                else abort_run($sformatf("FAIL %0t: head entry changed while not ready",
                                         $time));
        end
        if (deq_valid && deq_ready) begin    // transfer at the coming edge
            word = mem_word(exp_pc);
            assert (deq_pc == exp_pc)
                else abort_run($sformatf("FAIL %0t: deq_pc %h, expected %h",
                                         $time, deq_pc, exp_pc));
            assert (deq_instr == word)
                else abort_run($sformatf("FAIL %0t: deq_instr %h at %h, expected %h",
                                         $time, deq_instr, exp_pc, word));
            assert (deq_pred_taken == rule_taken(word))
                else abort_run($sformatf("FAIL %0t: deq_pred_taken %b at %h",
                                         $time, deq_pred_taken, exp_pc));
            assert (deq_pred_target == rule_next_pc(exp_pc, word))
                else abort_run($sformatf("FAIL %0t: deq_pred_target %h, expected %h",
                                         $time, deq_pred_target, rule_next_pc(exp_pc, word)));
            exp_pc = rule_next_pc(exp_pc, word);
            deq_count++;
            idle_cycles = 0;
        end else begin
            idle_cycles++;
        end
        if (redirect_valid) begin
            exp_pc = redirect_pc;  // fetch restarts here
        end
        held          = deq_valid && !deq_ready && !redirect_valid;
        held_instr    = deq_instr;
        held_pc       = deq_pc;
        held_taken    = deq_pred_taken;
        held_target   = deq_pred_target;
        prev_redirect = redirect_valid;
    endtask

    initial begin
        rng_state          = 32'd28725;
        arst_n             = 1'b0;
        redirect_valid     = 1'b0;
        redirect_pc        = '0;
        backend_stall      = 1'b0;
        deq_ready          = 1'b0;
        prdata             = '0;
        pready             = 1'b0;
        pslverr            = 1'b0;
        exp_pc             = '0;     // pc after reset
        cycle              = 0;
        deq_count          = 0;
        idle_cycles        = 0;
        ready_low          = 0;
        beat_active        = 1'b0;
        wait_left          = 0;
        in_refill          = 1'b0;
        retry_pending      = 1'b0;
        redirect_in_refill = 1'b0;
        refill_base        = '0;
        retry_base         = '0;
        beat_idx           = 0;
        prev_psel          = 1'b0;
        prev_penable       = 1'b0;
        prev_paddr         = '0;
        prev_redirect      = 1'b0;
        held               = 1'b0;
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        while (cycle < RUN_CYCLES || deq_count < MIN_DEQ) begin
            @(negedge clk);
            observe_apb();
            serve_apb();
            drive_backend();
            observe_dispatch();
            cycle++;
            if (idle_cycles > IDLE_LIMIT) begin
                abort_run($sformatf("no instruction was dequeued for %0d cycles", IDLE_LIMIT));
            end
            if (cycle >= MAX_CYCLES) begin
                abort_run($sformatf("only %0d instructions dequeued in %0d cycles",
                                    deq_count, MAX_CYCLES));
            end
        end
        $display("Test OK");
        $finish;
    end

endmodule

// ==== all.f ====
source/fetch_pkg.sv
source/mem_pkg.sv
source/pc_gen.sv
source/icache.sv
source/refill_fsm.sv
source/instr_fifo.sv
source/ifu_top.sv
verification/tb_ifu.sv

// ==== Bender.yml ====
package:
  name: ifu

sources:
  - source/fetch_pkg.sv
  - source/mem_pkg.sv
  - source/pc_gen.sv
  - source/icache.sv
  - source/refill_fsm.sv
  - source/instr_fifo.sv
  - source/ifu_top.sv
  - target: test
    files:
      - verification/tb_ifu.sv
